/* logic/gb_loader_settings.svh */
//////////////////////////////////////////////////////////////////////
// Loader constants: word and block widths, file-type codes, RTC block
//////////////////////////////////////////////////////////////////////
`ifndef GB_LOADER_SETTINGS_SVH
`define GB_LOADER_SETTINGS_SVH

// Download word, SD buffer word and save RAM word
`define GB_WORD_BITS 16
// 256 words of 16 bits per 512-byte block
`define GB_BLOCK_WORDS_LOG2 8
`define GB_BLOCK_BITS 8
// Save RAM depth in blocks, kept small for simulation
`define GB_SAVE_BLOCKS_LOG2 2

// Host file-type codes
`define GB_FT_CART 6'h01
`define GB_FT_CART_ALT 8'h80
`define GB_FT_PALETTE 8'h03
`define GB_FT_BOOT_CGB 8'h04
`define GB_FT_BOOT_DMG 8'h05
`define GB_FT_BOOT_SGB 8'h06
`define GB_FT_CHEAT 8'hff

// Used words at the start of the RTC block
`define GB_RTC_WORDS 5

`endif

/* logic/gb_loader_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Loader types: words, block numbers, cheat code, palette, file kind
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "gb_loader_settings.svh"

package gb_loader_pkg;

	typedef logic [`GB_WORD_BITS-1:0] word_t;
	typedef logic [`GB_BLOCK_BITS-1:0] block_t;

	// Download word k lands at bits 16k upward, so flags sit lowest
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_code_t;

	// Four colours per palette entry, word k at bits 16k upward
	typedef word_t [7:0] palette_t;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_CART,
		KIND_BOOT,
		KIND_PALETTE,
		KIND_CHEAT
	} file_kind_t;

endpackage

`default_nettype wire

/* logic/download_router.sv */
//////////////////////////////////////////////////////////////////////
// Download router: file-type decode, edge detection, write steering
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "gb_loader_settings.svh"

module download_router (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  ioctl_download,
	input  wire                  ioctl_wr,
	input  wire logic [24:0]     ioctl_addr,
	input  gb_loader_pkg::word_t ioctl_dout,
	input  wire logic [7:0]      filetype,
	output logic                 cart_download,
	output logic                 boot_download,
	output logic                 cart_done,
	output logic                 palette_wr,
	output logic                 cheat_wr,
	output logic                 cheat_clear,
	output logic [2:0]           word_index,
	output gb_loader_pkg::word_t word
);
	import gb_loader_pkg::*;

	file_kind_t kind_d;
	file_kind_t kind_q;
	logic       download_q;
	logic       dl_start;

	always_comb begin
		kind_d = KIND_NONE;
		if (ioctl_download) begin
			if (filetype[5:0] == `GB_FT_CART || filetype == `GB_FT_CART_ALT)
				kind_d = KIND_CART;
			else if (filetype == `GB_FT_PALETTE)
				kind_d = KIND_PALETTE;
			else if (filetype == `GB_FT_BOOT_CGB || filetype == `GB_FT_BOOT_DMG ||
					filetype == `GB_FT_BOOT_SGB)
				kind_d = KIND_BOOT;
			else if (filetype == `GB_FT_CHEAT)
				kind_d = KIND_CHEAT;
		end
	end

	assign cart_download = (kind_d == KIND_CART);
	assign boot_download = (kind_d == KIND_BOOT);
	assign dl_start = ioctl_download & ~download_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q  <= 1'b0;
			kind_q      <= KIND_NONE;
			cart_done   <= 1'b0;
			palette_wr  <= 1'b0;
			cheat_wr    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			download_q <= ioctl_download;
			kind_q     <= kind_d;
			// Previous cycle was a cartridge download, this one is not
			cart_done  <= (kind_q == KIND_CART) & ~cart_download;
			palette_wr <= ioctl_wr & (kind_d == KIND_PALETTE);
			cheat_wr   <= ioctl_wr & (kind_d == KIND_CHEAT);
			// A palette download shares the menu slot, so cheats are dropped
			cheat_clear <= (ioctl_wr & (kind_d == KIND_CHEAT) & (ioctl_addr == 25'd0)) |
					(dl_start & (kind_d == KIND_CART || kind_d == KIND_PALETTE));
		end
	end

	// Word index and data travel with the delayed strobes
	always_ff @(posedge clk_sys) begin
		word_index <= ioctl_addr[3:1];
		word       <= ioctl_dout;
	end

	a_even_addr: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> !ioctl_addr[0]);

endmodule

`default_nettype wire

/* logic/word_assembler.sv */
//////////////////////////////////////////////////////////////////////
// Word assembler: download words into one payload, commit strobe
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "gb_loader_settings.svh"

module word_assembler #(
	parameter type payload_t = logic [127:0]
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  clear,
	input  wire                  wr,
	input  wire logic [2:0]      word_index,
	input  gb_loader_pkg::word_t word,
	output payload_t             payload,
	output logic                 commit
);
	localparam int PAYLOAD_BITS = $bits(payload_t);
	localparam int SLOTS = PAYLOAD_BITS / `GB_WORD_BITS;

	logic [PAYLOAD_BITS-1:0] bits_q;

	// Clear first, so a write in the same cycle still lands its slot
	always_ff @(posedge clk_sys) begin
		if (clear)
			bits_q <= '0;
		if (wr)
			bits_q[word_index*`GB_WORD_BITS +: `GB_WORD_BITS] <= word;
	end

	assign payload = payload_t'(bits_q);

	// The last slot completes the payload
	always_ff @(posedge clk_sys) begin
		if (reset)
			commit <= 1'b0;
		else
			commit <= wr & (word_index == 3'(SLOTS - 1));
	end

	a_payload_width: assert property (@(posedge clk_sys)
		PAYLOAD_BITS == 8 * `GB_WORD_BITS);

endmodule

`default_nettype wire

/* logic/backup_ram.sv */
//////////////////////////////////////////////////////////////////////
// Save RAM with cartridge and SD buffer ports, RTC word mux
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "gb_loader_settings.svh"

module backup_ram (
	input  wire                   clk_sys,
	input  wire                   cram_wr,
	input  wire logic [9:0]       cram_addr,
	input  gb_loader_pkg::word_t  cram_data,
	input  gb_loader_pkg::block_t sd_lba,
	input  wire logic [7:0]       sd_buff_addr,
	input  gb_loader_pkg::word_t  sd_buff_dout,
	input  wire                   sd_buff_wr,
	input  wire                   sd_ack,
	input  gb_loader_pkg::block_t ram_mask,
	input  wire logic [31:0]      rtc_timestamp,
	input  wire logic [47:0]      rtc_savedtime,
	output gb_loader_pkg::word_t  sd_buff_din,
	output logic                  rtc_wr
);
	import gb_loader_pkg::*;

	localparam int BLK_LOG2 = `GB_SAVE_BLOCKS_LOG2;
	localparam int ADDR_BITS = BLK_LOG2 + `GB_BLOCK_WORDS_LOG2;

	word_t                ram [0:(1 << ADDR_BITS)-1];
	logic [ADDR_BITS-1:0] bk_addr;
	logic                 in_ram;
	logic                 bk_wr;
	word_t                rtc_word;

	assign bk_addr = {sd_lba[BLK_LOG2-1:0], sd_buff_addr};
	// Blocks past the RAM size carry the clock words
	assign in_ram  = (sd_lba <= ram_mask);
	assign bk_wr   = in_ram & sd_buff_wr & sd_ack;
	assign rtc_wr  = ~in_ram & sd_buff_wr & sd_ack;

	always_ff @(posedge clk_sys) begin
		if (cram_wr)
			ram[cram_addr] <= cram_data;
		if (bk_wr)
			ram[bk_addr] <= sd_buff_dout;
	end

	always_comb begin
		rtc_word = '1;
		if (sd_buff_addr < `GB_RTC_WORDS) begin
			case (sd_buff_addr[2:0])
				3'd0: rtc_word = rtc_timestamp[15:0];
				3'd1: rtc_word = rtc_timestamp[31:16];
				3'd2: rtc_word = rtc_savedtime[15:0];
				3'd3: rtc_word = rtc_savedtime[31:16];
				default: rtc_word = rtc_savedtime[47:32];
			endcase
		end
	end

	assign sd_buff_din = in_ram ? ram[bk_addr] : rtc_word;

endmodule

`default_nettype wire

/* logic/backup_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Backup sequencer: enable and pending flags, block transfer FSM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   cart_download,
	input  wire                   cart_done,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   cart_has_save,
	input  wire                   osd_status,
	input  wire                   autosave_en,
	input  wire                   load_req,
	input  wire                   save_req,
	input  wire                   cram_wr,
	input  wire                   rtc_inuse,
	input  gb_loader_pkg::block_t ram_mask,
	input  wire                   sd_ack,
	output gb_loader_pkg::block_t sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  sav_supported,
	output logic                  led_user
);
	import gb_loader_pkg::*;

	logic   cart_dl_q;
	logic   bk_ena;
	logic   sav_pending;
	logic   new_load;
	logic   bk_load;
	logic   bk_save;
	logic   old_load;
	logic   old_save;
	logic   old_ack;
	block_t last_block;

	assign sav_supported = bk_ena & cart_has_save;
	assign led_user      = cart_download | sav_pending;
	assign bk_load       = load_req | new_load;
	assign bk_save       = save_req | (sav_pending & osd_status & autosave_en);
	// One extra block holds the clock timestamp
	assign last_block    = rtc_inuse ? ram_mask + 8'd1 : ram_mask;

	////////////////////////////////////////////////////////////////////
	// Enable and request flags
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q   <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
			new_load    <= 1'b0;
		end else begin
			cart_dl_q <= cart_download;
			if (cart_download & ~cart_dl_q)
				bk_ena <= 1'b0;
			// The save image is mounted while the cartridge streams in
			if (cart_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
			if (cart_done & bk_ena)
				new_load <= 1'b1;
			else if (bk_busy)
				new_load <= 1'b0;
			if (cram_wr & ~osd_status & sav_supported)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Block transfer
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;
			// Host took the request
			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (bk_ena & ((~old_load & bk_load) | (~old_save & bk_save))) begin
					bk_busy    <= 1'b1;
					bk_loading <= bk_load;
					sd_lba     <= '0;
					sd_rd      <= bk_load;
					sd_wr      <= ~bk_load;
				end
			end else if (old_ack & ~sd_ack) begin
				if (sd_lba == last_block) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 8'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// A new block is only asked for between host acknowledges
	a_req_start: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd || sd_wr) |-> (bk_busy && !sd_ack));

endmodule

`default_nettype wire

/* logic/gb_loader_top.sv */
//////////////////////////////////////////////////////////////////////
// Loader top level: download routing, payload assembly, backup RAM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gb_loader_top (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ioctl_download,
	input  wire                         ioctl_wr,
	input  wire logic [24:0]            ioctl_addr,
	input  gb_loader_pkg::word_t        ioctl_dout,
	input  wire logic [7:0]             filetype,
	input  wire                         img_mounted,
	input  wire                         img_readonly,
	input  wire                         cart_has_save,
	input  wire                         osd_status,
	input  wire                         autosave_en,
	input  wire                         load_req,
	input  wire                         save_req,
	input  wire                         cram_wr,
	input  wire logic [9:0]             cram_addr,
	input  gb_loader_pkg::word_t        cram_data,
	input  wire                         rtc_inuse,
	input  gb_loader_pkg::block_t       ram_mask,
	input  wire logic [31:0]            rtc_timestamp,
	input  wire logic [47:0]            rtc_savedtime,
	input  wire                         sd_ack,
	input  wire logic [7:0]             sd_buff_addr,
	input  gb_loader_pkg::word_t        sd_buff_dout,
	input  wire                         sd_buff_wr,
	output gb_loader_pkg::block_t       sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output gb_loader_pkg::word_t        sd_buff_din,
	output logic                        rtc_wr,
	output logic                        led_user,
	output gb_loader_pkg::cheat_code_t  cheat_code,
	output logic                        cheat_valid,
	output gb_loader_pkg::palette_t     palette,
	output logic                        palette_valid,
	output logic                        cart_download,
	output logic                        boot_download,
	output logic                        bk_busy,
	output logic                        bk_loading,
	output logic                        sav_supported
);
	import gb_loader_pkg::*;

	logic       cart_done;
	logic       palette_wr;
	logic       cheat_wr;
	logic       cheat_clear;
	logic [2:0] word_index;
	word_t      dl_word;

	download_router u_router (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.filetype(filetype), .cart_download(cart_download),
		.boot_download(boot_download), .cart_done(cart_done),
		.palette_wr(palette_wr), .cheat_wr(cheat_wr), .cheat_clear(cheat_clear),
		.word_index(word_index), .word(dl_word)
	);

	word_assembler #(.payload_t(cheat_code_t)) u_cheat (
		.clk_sys(clk_sys), .reset(reset), .clear(cheat_clear), .wr(cheat_wr),
		.word_index(word_index), .word(dl_word), .payload(cheat_code),
		.commit(cheat_valid)
	);

	// Palette words are always rewritten in full
	word_assembler #(.payload_t(palette_t)) u_palette (
		.clk_sys(clk_sys), .reset(reset), .clear(1'b0), .wr(palette_wr),
		.word_index(word_index), .word(dl_word), .payload(palette),
		.commit(palette_valid)
	);

	backup_ram u_bram (
		.clk_sys(clk_sys), .cram_wr(cram_wr), .cram_addr(cram_addr),
		.cram_data(cram_data), .sd_lba(sd_lba), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr), .sd_ack(sd_ack),
		.ram_mask(ram_mask), .rtc_timestamp(rtc_timestamp),
		.rtc_savedtime(rtc_savedtime), .sd_buff_din(sd_buff_din), .rtc_wr(rtc_wr)
	);

	backup_sequencer u_seq (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.cart_done(cart_done), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .cart_has_save(cart_has_save),
		.osd_status(osd_status), .autosave_en(autosave_en), .load_req(load_req),
		.save_req(save_req), .cram_wr(cram_wr), .rtc_inuse(rtc_inuse),
		.ram_mask(ram_mask), .sd_ack(sd_ack), .sd_lba(sd_lba), .sd_rd(sd_rd),
		.sd_wr(sd_wr), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.sav_supported(sav_supported), .led_user(led_user)
	);

endmodule

`default_nettype wire

/* sim/tb_gb_loader_tasks.svh */
//////////////////////////////////////////////////////////////////////
// Directed loader tests: download decode, payloads, backup transfers
//////////////////////////////////////////////////////////////////////

task automatic end_with_failure();
	fail_count++;
	$display("TESTS FAILED");
	$fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_eq(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
	assert (actual === expected) else begin
		$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end_with_failure();
	end
endtask

// Block and word index both shape the image word
function automatic logic [15:0] image_word(input int blk, input int idx);
	return {4'(blk), 4'(blk), 8'(idx)} ^ 16'h5a3c;
endfunction

task automatic start_download(input logic [7:0] ft);
	@(posedge clk_sys);
	filetype       <= ft;
	ioctl_download <= 1'b1;
endtask

task automatic end_download();
	@(posedge clk_sys);
	ioctl_download <= 1'b0;
endtask

task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
	@(posedge clk_sys);
	ioctl_wr   <= 1'b1;
	ioctl_addr <= addr;
	ioctl_dout <= data;
	@(posedge clk_sys);
	ioctl_wr <= 1'b0;
endtask

task automatic pulse_save();
	@(posedge clk_sys);
	save_req <= 1'b1;
	@(posedge clk_sys);
	save_req <= 1'b0;
endtask

// Writes eight words at even addresses and watches the matching commit strobe
task automatic download_payload(input logic [7:0] ft, input logic [127:0] words,
		output int first, output int pulses);
	start_download(ft);
	for (int k = 0; k < 8; k++)
		write_word(25'(2 * k), words[16*k +: 16]);
	first = 0;
	pulses = 0;
	for (int n = 1; n <= 6; n++) begin
		@(negedge clk_sys);
		if ((ft == 8'hff) ? cheat_valid : palette_valid) begin
			pulses++;
			if (first == 0)
				first = n;
		end
	end
	end_download();
endtask

// Waits out one backup transfer from the rise of bk_busy to its fall
task automatic wait_transfer(input string name, input logic exp_loading);
	int idle;
	repeat (20) begin
		@(negedge clk_sys);
		if (bk_busy)
			break;
	end
	assert (bk_busy) else begin
		$display("%s: the backup transfer did not start", name);
		end_with_failure();
	end
	check_eq(name, 128'(exp_loading), 128'(bk_loading));
	idle = 0;
	while (bk_busy) begin
		@(negedge clk_sys);
		if (sd_ack)
			idle = 0;
		else if (bk_busy)
			idle++;
	end
	// Busy drops one cycle after the last acknowledge falls
	check_eq(name, 128'(1), 128'(idle));
endtask

////////////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////////////
task automatic file_type_decode();
	logic [7:0] codes [0:10] = '{8'h01, 8'h41, 8'hc1, 8'h80, 8'h03, 8'h04, 8'h05,
			8'h06, 8'hff, 8'h00, 8'h02};
	logic exp_cart;
	logic exp_boot;
	for (int i = 0; i < 11; i++) begin
		@(posedge clk_sys);
		filetype       <= codes[i];
		ioctl_download <= 1'b1;
		@(negedge clk_sys);
		// Cartridge codes have the low six bits equal to 1 or are 0x80
		exp_cart = (codes[i][5:0] == 6'h01) || (codes[i] == 8'h80);
		exp_boot = (codes[i] >= 8'h04) && (codes[i] <= 8'h06);
		check_eq("download_decode", 128'({exp_cart, exp_boot}),
				128'({cart_download, boot_download}));
	end
	end_download();
	@(negedge clk_sys);
	check_eq("download_decode", 128'(0), 128'({cart_download, boot_download}));
endtask

task automatic cheat_download();
	logic [127:0] words;
	int first;
	int pulses;
	words = {$urandom, $urandom, $urandom, $urandom};
	download_payload(8'hff, words, first, pulses);
	check_eq("cheat_load", 128'(2), 128'(first));
	check_eq("cheat_load", 128'(1), 128'(pulses));
	check_eq("cheat_load", words, cheat_code);
	// The start of a palette download drops the code
	start_download(8'h03);
	repeat (3) @(negedge clk_sys);
	check_eq("cheat_clear", 128'(0), cheat_code);
	end_download();
endtask

task automatic palette_download();
	logic [127:0] words;
	int first;
	int pulses;
	words = {$urandom, $urandom, $urandom, $urandom};
	download_payload(8'h03, words, first, pulses);
	check_eq("palette_load", 128'(2), 128'(first));
	check_eq("palette_load", 128'(1), 128'(pulses));
	for (int k = 0; k < 8; k++)
		check_eq("palette_load", 128'(words[16*k +: 16]), 128'(palette[16*k +: 16]));
endtask

task automatic backup_round_trip();
	for (int b = 0; b < 8; b++)
		for (int i = 0; i < 256; i++)
			sd_image[b][i] = image_word(b, i);
	blocks_read = 0;
	rtc_writes = 0;
	start_download(8'h01);
	@(posedge clk_sys);
	img_mounted <= 1'b1;
	@(posedge clk_sys);
	img_mounted <= 1'b0;
	end_download();
	wait_transfer("backup_load", 1'b1);
	check_eq("backup_load", 128'(ram_mask) + 128'd1, 128'(blocks_read));
	check_eq("backup_load", 128'(0), 128'(rtc_writes));
	check_eq("backup_load", 128'(1), 128'(sav_supported));
	blocks_written = 0;
	pulse_save();
	wait_transfer("backup_save", 1'b0);
	check_eq("backup_save", 128'(ram_mask) + 128'd1, 128'(blocks_written));
	for (int b = 0; b <= 1; b++)
		for (int i = 0; i < 256; i++)
			check_eq("backup_save", 128'(image_word(b, i)), 128'(sd_saved[b][i]));
endtask

task automatic rtc_block_transfer();
	logic [31:0] ts;
	logic [47:0] st;
	logic [79:0] rtc_words;
	logic [15:0] exp;
	ts = $urandom;
	st = {16'($urandom), $urandom};
	// Timestamp low and high words come before the three saved-time words
	rtc_words = {st, ts};
	@(posedge clk_sys);
	rtc_inuse     <= 1'b1;
	rtc_timestamp <= ts;
	rtc_savedtime <= st;
	blocks_written = 0;
	pulse_save();
	wait_transfer("rtc_block", 1'b0);
	check_eq("rtc_block", 128'(ram_mask) + 128'd2, 128'(blocks_written));
	for (int i = 0; i < 256; i++) begin
		exp = 16'hffff;
		if (i < 5)
			exp = rtc_words[16*i +: 16];
		check_eq("rtc_block", 128'(exp), 128'(sd_saved[2][i]));
	end
	// Every word of the extra block read back goes to the clock
	blocks_read = 0;
	rtc_writes = 0;
	@(posedge clk_sys);
	load_req <= 1'b1;
	@(posedge clk_sys);
	load_req <= 1'b0;
	wait_transfer("rtc_load", 1'b1);
	check_eq("rtc_load", 128'(ram_mask) + 128'd2, 128'(blocks_read));
	check_eq("rtc_load", 128'd256, 128'(rtc_writes));
	@(posedge clk_sys);
	rtc_inuse <= 1'b0;
endtask

task automatic autosave_on_menu();
	logic [15:0] data;
	data = 16'($urandom);
	@(posedge clk_sys);
	autosave_en <= 1'b1;
	cram_wr     <= 1'b1;
	cram_addr   <= 10'h105;
	cram_data   <= data;
	@(posedge clk_sys);
	cram_wr <= 1'b0;
	@(negedge clk_sys);
	check_eq("autosave", 128'(1), 128'(led_user));
	blocks_written = 0;
	@(posedge clk_sys);
	osd_status <= 1'b1;
	wait_transfer("autosave", 1'b0);
	check_eq("autosave", 128'(0), 128'(led_user));
	check_eq("autosave", 128'(ram_mask) + 128'd1, 128'(blocks_written));
	// Address 0x105 is word 5 of block 1
	check_eq("autosave", 128'(data), 128'(sd_saved[1][5]));
	@(posedge clk_sys);
	osd_status <= 1'b0;
endtask

/* sim/tb_gb_loader.sv */
//////////////////////////////////////////////////////////////////////
// Loader testbench: clock, reset, DUT, SD host model, test sequence
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_gb_loader;

	// The six tests take well under 4000 cycles in all
	localparam int TIMEOUT_CYCLES = 40000;
	localparam logic [31:0] SEED = 32'h0616_c306;

	logic clk_sys;
	logic reset;
	// Host download port
	logic ioctl_download, ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [7:0] filetype;
	// Image, menu and cartridge side
	logic img_mounted, img_readonly, cart_has_save, osd_status, autosave_en;
	logic load_req, save_req, cram_wr, rtc_inuse;
	logic [9:0] cram_addr;
	logic [15:0] cram_data;
	logic [7:0] ram_mask;
	logic [31:0] rtc_timestamp;
	logic [47:0] rtc_savedtime;
	// SD block port
	logic sd_ack, sd_buff_wr, sd_rd, sd_wr, rtc_wr;
	logic [7:0] sd_buff_addr, sd_lba;
	logic [15:0] sd_buff_dout, sd_buff_din;
	// Payloads and status
	logic [127:0] cheat_code, palette;
	logic cheat_valid, palette_valid, led_user, cart_download, boot_download;
	logic bk_busy, bk_loading, sav_supported;

	logic [15:0] sd_image [0:7][0:255];
	logic [15:0] sd_saved [0:7][0:255];
	int blocks_read;
	int blocks_written;
	int rtc_writes;
	int cycle_count;
	int fail_count;

	gb_loader_top u_dut (.*);

	`include "tb_gb_loader_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// SD host model acknowledges after 3 cycles and then streams or captures one block
	initial begin : sd_host
		int blk;
		logic is_read;
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				is_read = sd_rd;
				blk = int'(sd_lba[2:0]);
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b1;
				for (int i = 0; i < 256; i++) begin
					@(posedge clk_sys);
					sd_buff_addr <= 8'(i);
					sd_buff_wr   <= is_read;
					sd_buff_dout <= sd_image[blk][i];
					if (!is_read) begin
						@(negedge clk_sys);
						sd_saved[blk][i] = sd_buff_din;
					end
				end
				@(posedge clk_sys);
				sd_ack     <= 1'b0;
				sd_buff_wr <= 1'b0;
				if (is_read)
					blocks_read++;
				else
					blocks_written++;
			end
		end
	end

	// Clock words taken from the SD side during a load
	always @(negedge clk_sys) begin
		if (rtc_wr)
			rtc_writes++;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	initial begin
		void'($urandom(SEED));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		filetype       = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		cart_has_save  = 1'b1;
		osd_status     = 1'b0;
		autosave_en    = 1'b0;
		load_req       = 1'b0;
		save_req       = 1'b0;
		cram_wr        = 1'b0;
		cram_addr      = '0;
		cram_data      = '0;
		rtc_inuse      = 1'b0;
		ram_mask       = 8'd1;
		rtc_timestamp  = '0;
		rtc_savedtime  = '0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_eq("reset_state", 128'(0), 128'({sd_rd, sd_wr, bk_busy, bk_loading,
				led_user, cheat_valid, palette_valid}));
		file_type_decode();
		cheat_download();
		palette_download();
		backup_round_trip();
		rtc_block_transfer();
		autosave_on_menu();
		if (fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+sim
logic/gb_loader_pkg.sv
logic/download_router.sv
logic/word_assembler.sv
logic/backup_ram.sv
logic/backup_sequencer.sv
logic/gb_loader_top.sv
sim/tb_gb_loader.sv

/* Makefile */
# Verilator build, run and lint for the loader testbench
TOP = tb_gb_loader

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall -f verilog.f --top-module gb_loader_top

clean:
	rm -rf obj_dir sim.log
